//--- cmac_pkg.sv
/*
 * cmac link control package
 * shared widths, counter count and the state and counter-select encodings
 */
package cmac_pkg;

    localparam int count_w   = 32;  // every statistics counter
    localparam int num_stats = 15;

    // raw per-cycle statistic widths as the mac core presents them
    localparam int rx_total_bytes_w = 7;
    localparam int rx_good_bytes_w  = 14;
    localparam int rx_total_pkts_w  = 3;
    localparam int tx_total_bytes_w = 6;
    localparam int tx_good_bytes_w  = 14;
    localparam int fcs_w            = 3;  // bad_code uses the same width

    // counter index, also the readout select code
    typedef enum logic [3:0] {
        rx_good_pkts,
        rx_total_pkts,
        rx_good_bytes,
        rx_total_bytes,
        tx_good_pkts,
        tx_total_pkts,
        tx_good_bytes,
        tx_total_bytes,
        rx_align_err,
        rx_code_err,
        rx_fcs_err,
        rx_preamble_err,
        rx_sfd_err,
        tx_ovf,
        tx_unf
    } stat_id_e;

    // receive bring-up states
    typedef enum logic [1:0] {
        rx_idle,
        rx_gt_locked,
        rx_wait_aligned,
        rx_transfer
    } rx_state_e;

    // transmit bring-up states, same sequence as receive
    typedef enum logic [1:0] {
        tx_idle,
        tx_gt_locked,
        tx_wait_aligned,
        tx_transfer
    } tx_state_e;

endpackage

//--- stat_bus_if.sv
/*
 * statistics bus
 * per-lane increments from capture and accumulated counts for readout
 */
`timescale 1ns/1ps

interface stat_bus_if;

    logic [cmac_pkg::count_w-1:0] incr  [cmac_pkg::num_stats];  // added every cycle
    logic [cmac_pkg::count_w-1:0] count [cmac_pkg::num_stats];  // running totals

    // capture stage fills every increment lane
    modport capture (
        output incr
    );

    // each counter owns one lane of both arrays
    modport counter (
        input  incr,
        output count
    );

    // readout only looks at the totals
    modport readout (
        input  count
    );

endinterface

//--- link_bringup.sv
/*
 * link bring-up control
 * rx and tx control FSMs driving the mac enables and fault indications
 */
`timescale 1ns/1ps

module link_bringup (
    input  logic cmac_drp,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic ctl_rx_enable,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_lfi,
    output logic ctl_tx_send_rfi
);

    cmac_pkg::rx_state_e rx_state;
    cmac_pkg::tx_state_e tx_state;

    logic reset_done;
    logic stat_rx_aligned_1d;
    logic align_lost;

    // both machines leave transfer on the same condition
    assign align_lost = (rx_state == cmac_pkg::rx_transfer) && !stat_rx_aligned_1d;

    // a drop in alignment re-runs the reset-done qualification
    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            reset_done         <= 1'b0;
            stat_rx_aligned_1d <= 1'b0;
        end else begin
            reset_done         <= !align_lost;
            stat_rx_aligned_1d <= stat_rx_aligned;  // one register stage only
        end
    end

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            rx_state      <= cmac_pkg::rx_idle;
            ctl_rx_enable <= 1'b0;
        end else begin
            case (rx_state)
                cmac_pkg::rx_idle: begin
                    ctl_rx_enable <= 1'b0;
                    if (reset_done) begin
                        rx_state <= cmac_pkg::rx_gt_locked;
                    end
                end
                cmac_pkg::rx_gt_locked: begin
                    ctl_rx_enable <= 1'b1;  // receiver runs from here on
                    rx_state      <= cmac_pkg::rx_wait_aligned;
                end
                cmac_pkg::rx_wait_aligned: begin
                    if (stat_rx_aligned_1d) begin
                        rx_state <= cmac_pkg::rx_transfer;
                    end
                end
                cmac_pkg::rx_transfer: begin
                    if (!stat_rx_aligned_1d) begin
                        rx_state <= cmac_pkg::rx_idle;
                    end
                end
                default: begin
                    rx_state <= cmac_pkg::rx_idle;
                end
            endcase
        end
    end

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            tx_state        <= cmac_pkg::tx_idle;
            ctl_tx_enable   <= 1'b0;
            ctl_tx_send_lfi <= 1'b0;
            ctl_tx_send_rfi <= 1'b0;
        end else begin
            case (tx_state)
                cmac_pkg::tx_idle: begin
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (reset_done) begin
                        tx_state <= cmac_pkg::tx_gt_locked;
                    end
                end
                cmac_pkg::tx_gt_locked: begin
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b1;  // signal faults until rx aligns
                    ctl_tx_send_rfi <= 1'b1;
                    tx_state        <= cmac_pkg::tx_wait_aligned;
                end
                cmac_pkg::tx_wait_aligned: begin
                    if (stat_rx_aligned_1d) begin
                        tx_state <= cmac_pkg::tx_transfer;
                    end
                end
                cmac_pkg::tx_transfer: begin
                    ctl_tx_enable   <= 1'b1;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (!stat_rx_aligned_1d) begin
                        tx_state <= cmac_pkg::tx_idle;
                    end
                end
                default: begin
                    tx_state <= cmac_pkg::tx_idle;
                end
            endcase
        end
    end

endmodule

//--- stat_capture.sv
/*
 * statistics capture
 * registers the raw mac statistics as one 32-bit increment per counter
 */
`timescale 1ns/1ps

module stat_capture (
    input  logic                                  cmac_drp,
    input  logic                                  usr_rx_reset_w,
    input  logic [cmac_pkg::rx_total_bytes_w-1:0] stat_rx_total_bytes,
    input  logic [cmac_pkg::rx_good_bytes_w-1:0]  stat_rx_good_bytes,
    input  logic                                  stat_rx_good_packets,
    input  logic [cmac_pkg::rx_total_pkts_w-1:0]  stat_rx_total_packets,
    input  logic [cmac_pkg::tx_total_bytes_w-1:0] stat_tx_total_bytes,
    input  logic [cmac_pkg::tx_good_bytes_w-1:0]  stat_tx_good_bytes,
    input  logic                                  stat_tx_good_packets,
    input  logic                                  stat_tx_total_packets,
    input  logic                                  stat_rx_aligned_err,
    input  logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_code,
    input  logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_fcs,
    input  logic                                  stat_rx_bad_preamble,
    input  logic                                  stat_rx_bad_sfd,
    input  logic                                  tx_ovf,
    input  logic                                  tx_unf,
    stat_bus_if.capture                           bus
);

    localparam int cw = cmac_pkg::count_w;

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < cmac_pkg::num_stats; i++) begin
                bus.incr[i] <= '0;
            end
        end else begin
            // packet and byte counts, zero-extended
            bus.incr[cmac_pkg::rx_good_pkts] <= {{(cw-1){1'b0}}, stat_rx_good_packets};
            bus.incr[cmac_pkg::rx_total_pkts] <=
                {{(cw-cmac_pkg::rx_total_pkts_w){1'b0}}, stat_rx_total_packets};
            bus.incr[cmac_pkg::rx_good_bytes] <=
                {{(cw-cmac_pkg::rx_good_bytes_w){1'b0}}, stat_rx_good_bytes};
            bus.incr[cmac_pkg::rx_total_bytes] <=
                {{(cw-cmac_pkg::rx_total_bytes_w){1'b0}}, stat_rx_total_bytes};
            bus.incr[cmac_pkg::tx_good_pkts]  <= {{(cw-1){1'b0}}, stat_tx_good_packets};
            bus.incr[cmac_pkg::tx_total_pkts] <= {{(cw-1){1'b0}}, stat_tx_total_packets};
            bus.incr[cmac_pkg::tx_good_bytes] <=
                {{(cw-cmac_pkg::tx_good_bytes_w){1'b0}}, stat_tx_good_bytes};
            bus.incr[cmac_pkg::tx_total_bytes] <=
                {{(cw-cmac_pkg::tx_total_bytes_w){1'b0}}, stat_tx_total_bytes};

            // error events count once per cycle, whatever the raw value
            bus.incr[cmac_pkg::rx_align_err]    <= {{(cw-1){1'b0}}, stat_rx_aligned_err};
            bus.incr[cmac_pkg::rx_code_err]     <= {{(cw-1){1'b0}}, |stat_rx_bad_code};
            bus.incr[cmac_pkg::rx_fcs_err]      <= {{(cw-1){1'b0}}, |stat_rx_bad_fcs};
            bus.incr[cmac_pkg::rx_preamble_err] <= {{(cw-1){1'b0}}, stat_rx_bad_preamble};
            bus.incr[cmac_pkg::rx_sfd_err]      <= {{(cw-1){1'b0}}, stat_rx_bad_sfd};
            bus.incr[cmac_pkg::tx_ovf]          <= {{(cw-1){1'b0}}, tx_ovf};
            bus.incr[cmac_pkg::tx_unf]          <= {{(cw-1){1'b0}}, tx_unf};
        end
    end

endmodule

//--- stat_counter.sv
/*
 * statistics counter
 * wrapping 32-bit accumulator for one increment lane
 */
`timescale 1ns/1ps

module stat_counter #(
    parameter int lane = 0  // generate index of the lane owned here
) (
    input  logic        cmac_drp,
    input  logic        usr_rx_reset_w,
    stat_bus_if.counter bus
);

    logic [cmac_pkg::count_w-1:0] acc;

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            acc <= '0;
        end else begin
            acc <= acc + bus.incr[lane];  // wraps at 2**32
        end
    end

    assign bus.count[lane] = acc;

endmodule

//--- stat_readout.sv
/*
 * statistics readout
 * registered selection of one counter by its select code
 */
`timescale 1ns/1ps

module stat_readout (
    input  logic                         cmac_drp,
    input  logic                         usr_rx_reset_w,
    input  cmac_pkg::stat_id_e           stat_sel,
    stat_bus_if.readout                  bus,
    output logic [cmac_pkg::count_w-1:0] rd_data
);

    logic sel_valid;

    // codes past the last counter have no register behind them
    assign sel_valid = int'(stat_sel) < cmac_pkg::num_stats;

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            rd_data <= '0;
        end else if (sel_valid) begin
            rd_data <= bus.count[stat_sel];
        end else begin
            rd_data <= '0;  // unused code reads zero
        end
    end

endmodule

//--- cmac_link_ctrl.sv
/*
 * cmac link control top
 * link bring-up FSMs plus statistics capture, counters and readout
 */
`timescale 1ns/1ps

module cmac_link_ctrl (
    input  logic                                  cmac_drp,
    input  logic                                  usr_rx_reset_w,
    input  logic                                  stat_rx_aligned,
    input  logic [cmac_pkg::rx_total_bytes_w-1:0] stat_rx_total_bytes,
    input  logic [cmac_pkg::rx_good_bytes_w-1:0]  stat_rx_good_bytes,
    input  logic                                  stat_rx_good_packets,
    input  logic [cmac_pkg::rx_total_pkts_w-1:0]  stat_rx_total_packets,
    input  logic [cmac_pkg::tx_total_bytes_w-1:0] stat_tx_total_bytes,
    input  logic [cmac_pkg::tx_good_bytes_w-1:0]  stat_tx_good_bytes,
    input  logic                                  stat_tx_good_packets,
    input  logic                                  stat_tx_total_packets,
    input  logic                                  stat_rx_aligned_err,
    input  logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_code,
    input  logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_fcs,
    input  logic                                  stat_rx_bad_preamble,
    input  logic                                  stat_rx_bad_sfd,
    input  logic                                  tx_ovf,
    input  logic                                  tx_unf,
    input  cmac_pkg::stat_id_e                    stat_sel,
    output logic                                  ctl_rx_enable,
    output logic                                  ctl_tx_enable,
    output logic                                  ctl_tx_send_lfi,
    output logic                                  ctl_tx_send_rfi,
    output logic [cmac_pkg::count_w-1:0]          rd_data
);

    stat_bus_if stat_bus ();

    link_bringup link_bringup_i (
        .cmac_drp        (cmac_drp),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .ctl_rx_enable   (ctl_rx_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_lfi (ctl_tx_send_lfi),
        .ctl_tx_send_rfi (ctl_tx_send_rfi)
    );

    stat_capture stat_capture_i (
        .cmac_drp              (cmac_drp),
        .usr_rx_reset_w        (usr_rx_reset_w),
        .stat_rx_total_bytes   (stat_rx_total_bytes),
        .stat_rx_good_bytes    (stat_rx_good_bytes),
        .stat_rx_good_packets  (stat_rx_good_packets),
        .stat_rx_total_packets (stat_rx_total_packets),
        .stat_tx_total_bytes   (stat_tx_total_bytes),
        .stat_tx_good_bytes    (stat_tx_good_bytes),
        .stat_tx_good_packets  (stat_tx_good_packets),
        .stat_tx_total_packets (stat_tx_total_packets),
        .stat_rx_aligned_err   (stat_rx_aligned_err),
        .stat_rx_bad_code      (stat_rx_bad_code),
        .stat_rx_bad_fcs       (stat_rx_bad_fcs),
        .stat_rx_bad_preamble  (stat_rx_bad_preamble),
        .stat_rx_bad_sfd       (stat_rx_bad_sfd),
        .tx_ovf                (tx_ovf),
        .tx_unf                (tx_unf),
        .bus                   (stat_bus.capture)
    );

    // one accumulator per stat_id_e code
    for (genvar i = 0; i < cmac_pkg::num_stats; i++) begin : g_counter
        stat_counter #(
            .lane (i)
        ) stat_counter_i (
            .cmac_drp       (cmac_drp),
            .usr_rx_reset_w (usr_rx_reset_w),
            .bus            (stat_bus.counter)
        );
    end

    stat_readout stat_readout_i (
        .cmac_drp       (cmac_drp),
        .usr_rx_reset_w (usr_rx_reset_w),
        .stat_sel       (stat_sel),
        .bus            (stat_bus.readout),
        .rd_data        (rd_data)
    );

endmodule

//--- cmac_link_ctrl_properties.sv
/*
 * link bring-up assertions
 * output consistency of the rx and tx control FSMs
 */
`timescale 1ns/1ps

module cmac_link_ctrl_properties (
    input logic                cmac_drp,
    input logic                usr_rx_reset_w,
    input cmac_pkg::rx_state_e rx_state,
    input cmac_pkg::tx_state_e tx_state,
    input logic                ctl_rx_enable,
    input logic                ctl_tx_enable,
    input logic                ctl_tx_send_lfi,
    input logic                ctl_tx_send_rfi
);

    tx_not_with_fault: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        !(ctl_tx_enable && ctl_tx_send_lfi))
        else $error("tx enabled while local fault is sent");

    fault_pair: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        ctl_tx_send_lfi == ctl_tx_send_rfi)
        else $error("local and remote fault sends differ");

    tx_needs_rx: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        ctl_tx_enable |-> ctl_rx_enable)
        else $error("tx enabled without rx enabled");

    // receiver is still off while gt-locked
    rx_enable_state: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        ctl_rx_enable |-> rx_state != cmac_pkg::rx_gt_locked)
        else $error("rx enabled in the gt-locked state");

    // tx enable only in transfer or on the first idle cycle after it
    tx_enable_state: assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        ctl_tx_enable |-> tx_state inside {cmac_pkg::tx_transfer, cmac_pkg::tx_idle})
        else $error("tx enabled outside transfer");

    reset_clears: assert property (@(posedge cmac_drp)
        usr_rx_reset_w |=> !ctl_rx_enable && !ctl_tx_enable &&
                           !ctl_tx_send_lfi && !ctl_tx_send_rfi)
        else $error("control output high after reset");

endmodule

bind link_bringup cmac_link_ctrl_properties link_bringup_props_i (
    .cmac_drp        (cmac_drp),
    .usr_rx_reset_w  (usr_rx_reset_w),
    .rx_state        (rx_state),
    .tx_state        (tx_state),
    .ctl_rx_enable   (ctl_rx_enable),
    .ctl_tx_enable   (ctl_tx_enable),
    .ctl_tx_send_lfi (ctl_tx_send_lfi),
    .ctl_tx_send_rfi (ctl_tx_send_rfi)
);

//--- tb_cmac_link_ctrl.sv
/*
 * testbench for the cmac link control top
 * random stimulus checked against a bring-up model and per-counter sums
 */
`timescale 1ns/1ps

module tb_cmac_link_ctrl;

    logic                                  cmac_drp;
    logic                                  usr_rx_reset_w;
    logic                                  stat_rx_aligned;
    logic [cmac_pkg::rx_total_bytes_w-1:0] stat_rx_total_bytes;
    logic [cmac_pkg::rx_good_bytes_w-1:0]  stat_rx_good_bytes;
    logic                                  stat_rx_good_packets;
    logic [cmac_pkg::rx_total_pkts_w-1:0]  stat_rx_total_packets;
    logic [cmac_pkg::tx_total_bytes_w-1:0] stat_tx_total_bytes;
    logic [cmac_pkg::tx_good_bytes_w-1:0]  stat_tx_good_bytes;
    logic                                  stat_tx_good_packets;
    logic                                  stat_tx_total_packets;
    logic                                  stat_rx_aligned_err;
    logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_code;
    logic [cmac_pkg::fcs_w-1:0]            stat_rx_bad_fcs;
    logic                                  stat_rx_bad_preamble;
    logic                                  stat_rx_bad_sfd;
    logic                                  tx_ovf;
    logic                                  tx_unf;
    cmac_pkg::stat_id_e                    stat_sel;
    logic                                  ctl_rx_enable;
    logic                                  ctl_tx_enable;
    logic                                  ctl_tx_send_lfi;
    logic                                  ctl_tx_send_rfi;
    logic [cmac_pkg::count_w-1:0]          rd_data;

    logic [cmac_pkg::count_w-1:0] sums [cmac_pkg::num_stats];  // expected counter values
    cmac_pkg::rx_state_e          m_phase;                     // shared by both FSMs
    logic                         m_done;
    logic                         m_aligned_q;
    logic                         m_rx_en;
    logic                         m_tx_en;
    logic                         m_fault;                     // lfi and rfi together

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          edges;
    int          test_errs;

    cmac_link_ctrl cmac_link_ctrl_i (.*);

    initial begin
        cmac_drp = 1'b0;
        forever #2 cmac_drp = ~cmac_drp;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // one rising edge of the models, using the inputs the DUT samples at that edge
    task automatic model_step();
        cmac_pkg::rx_state_e nxt;
        logic                lost;
        if (usr_rx_reset_w) begin
            m_phase     = cmac_pkg::rx_idle;
            m_done      = 1'b0;
            m_aligned_q = 1'b0;
            m_rx_en     = 1'b0;
            m_tx_en     = 1'b0;
            m_fault     = 1'b0;
            for (int i = 0; i < cmac_pkg::num_stats; i++) begin
                sums[i] = '0;
            end
        end else begin
            lost = (m_phase == cmac_pkg::rx_transfer) && !m_aligned_q;
            nxt  = m_phase;
            case (m_phase)
                cmac_pkg::rx_idle: begin
                    m_rx_en = 1'b0;
                    m_tx_en = 1'b0;
                    m_fault = 1'b0;
                    if (m_done) nxt = cmac_pkg::rx_gt_locked;
                end
                cmac_pkg::rx_gt_locked: begin
                    m_rx_en = 1'b1;
                    m_tx_en = 1'b0;
                    m_fault = 1'b1;  // faults go out until alignment
                    nxt     = cmac_pkg::rx_wait_aligned;
                end
                cmac_pkg::rx_wait_aligned: begin
                    if (m_aligned_q) nxt = cmac_pkg::rx_transfer;
                end
                default: begin
                    m_tx_en = 1'b1;
                    m_fault = 1'b0;
                    if (!m_aligned_q) nxt = cmac_pkg::rx_idle;
                end
            endcase
            m_done      = !lost;  // loss of alignment restarts the done qualification
            m_aligned_q = stat_rx_aligned;
            m_phase     = nxt;

            sums[cmac_pkg::rx_good_pkts]    += 32'(stat_rx_good_packets);
            sums[cmac_pkg::rx_total_pkts]   += 32'(stat_rx_total_packets);
            sums[cmac_pkg::rx_good_bytes]   += 32'(stat_rx_good_bytes);
            sums[cmac_pkg::rx_total_bytes]  += 32'(stat_rx_total_bytes);
            sums[cmac_pkg::tx_good_pkts]    += 32'(stat_tx_good_packets);
            sums[cmac_pkg::tx_total_pkts]   += 32'(stat_tx_total_packets);
            sums[cmac_pkg::tx_good_bytes]   += 32'(stat_tx_good_bytes);
            sums[cmac_pkg::tx_total_bytes]  += 32'(stat_tx_total_bytes);
            sums[cmac_pkg::rx_align_err]    += 32'(stat_rx_aligned_err);
            sums[cmac_pkg::rx_code_err]     += 32'(stat_rx_bad_code != '0);  // any value is one event
            sums[cmac_pkg::rx_fcs_err]      += 32'(stat_rx_bad_fcs != '0);
            sums[cmac_pkg::rx_preamble_err] += 32'(stat_rx_bad_preamble);
            sums[cmac_pkg::rx_sfd_err]      += 32'(stat_rx_bad_sfd);
            sums[cmac_pkg::tx_ovf]          += 32'(tx_ovf);
            sums[cmac_pkg::tx_unf]          += 32'(tx_unf);
        end
    endtask

    // advance one cycle and compare the control outputs at the falling edge
    task automatic tick();
        model_step();
        @(posedge cmac_drp);
        @(negedge cmac_drp);
        check_value(32'(ctl_rx_enable), 32'(m_rx_en), "ctl_rx_enable");
        check_value(32'(ctl_tx_enable), 32'(m_tx_en), "ctl_tx_enable");
        check_value(32'(ctl_tx_send_lfi), 32'(m_fault), "ctl_tx_send_lfi");
        check_value(32'(ctl_tx_send_rfi), 32'(m_fault), "ctl_tx_send_rfi");
    endtask

    task automatic wait_control(input int which, input logic level, input int limit,
                                input string name, output int n);
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < limit) begin
            tick();
            n++;
            case (which)
                0:       hit = (ctl_rx_enable == level);
                1:       hit = (ctl_tx_enable == level);
                default: hit = (ctl_tx_send_lfi == level);
            endcase
        end
        if (!hit) begin
            errors++;
            $display("Timeout: %s did not reach %0b within %0d cycles", name, level, limit);
        end
    endtask

    task automatic zero_stats();
        stat_rx_total_bytes   = '0;
        stat_rx_good_bytes    = '0;
        stat_rx_good_packets  = 1'b0;
        stat_rx_total_packets = '0;
        stat_tx_total_bytes   = '0;
        stat_tx_good_bytes    = '0;
        stat_tx_good_packets  = 1'b0;
        stat_tx_total_packets = 1'b0;
        stat_rx_aligned_err   = 1'b0;
        stat_rx_bad_code      = '0;
        stat_rx_bad_fcs       = '0;
        stat_rx_bad_preamble  = 1'b0;
        stat_rx_bad_sfd       = 1'b0;
        tx_ovf                = 1'b0;
        tx_unf                = 1'b0;
    endtask

    task automatic drive_traffic();
        rng = xorshift32(rng);
        stat_rx_good_bytes    = rng[13:0];
        stat_rx_total_bytes   = rng[20:14];
        stat_rx_total_packets = rng[23:21];
        stat_rx_good_packets  = rng[24];
        rng = xorshift32(rng);
        stat_tx_good_bytes    = rng[13:0];
        stat_tx_total_bytes   = rng[19:14];
        stat_tx_good_packets  = rng[20];
        stat_tx_total_packets = rng[21];
    endtask

    task automatic drive_errors();
        rng = xorshift32(rng);
        stat_rx_bad_code     = rng[2:0];  // multi-bit, zero one cycle in eight
        stat_rx_bad_fcs      = rng[5:3];
        stat_rx_aligned_err  = rng[6] & rng[7];
        stat_rx_bad_preamble = rng[8];
        stat_rx_bad_sfd      = rng[9] & rng[10];
        tx_ovf               = rng[11];
        tx_unf               = rng[12] | rng[13];
    endtask

    task automatic read_counters(input int first, input int last);
        cmac_pkg::stat_id_e id;
        for (int i = first; i <= last; i++) begin
            id       = cmac_pkg::stat_id_e'(4'(i));
            stat_sel = id;
            tick();  // rd_data registers the selection on this edge
            check_value(rd_data, sums[i], id.name());
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        rng             = 32'hee30_3ad9;
        checks          = 0;
        errors          = 0;
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        stat_sel        = cmac_pkg::rx_good_pkts;
        zero_stats();

        test_errs = errors;
        repeat (10) tick();
        usr_rx_reset_w = 1'b0;
        wait_control(0, 1'b1, 20, "ctl_rx_enable", edges);
        check_value(32'(edges), 32'd3, "edges from reset release to rx enable");
        check_value(32'(ctl_tx_send_lfi), 32'd1, "ctl_tx_send_lfi after bring-up");
        check_value(32'(ctl_tx_send_rfi), 32'd1, "ctl_tx_send_rfi after bring-up");
        check_value(32'(ctl_tx_enable), 32'd0, "ctl_tx_enable after bring-up");
        report_test("reset and bring-up", test_errs);

        test_errs = errors;
        stat_rx_aligned = 1'b1;
        wait_control(1, 1'b1, 20, "ctl_tx_enable", edges);
        check_value(32'(edges), 32'd3, "edges from alignment to tx enable");
        check_value(32'(ctl_tx_send_lfi), 32'd0, "ctl_tx_send_lfi once aligned");
        check_value(32'(ctl_tx_send_rfi), 32'd0, "ctl_tx_send_rfi once aligned");
        report_test("alignment", test_errs);

        test_errs = errors;
        stat_rx_aligned = 1'b0;
        wait_control(0, 1'b0, 20, "ctl_rx_enable", edges);
        check_value(32'(edges), 32'd3, "edges from loss to rx disable");
        check_value(32'(ctl_tx_enable), 32'd0, "ctl_tx_enable after loss");
        wait_control(0, 1'b1, 20, "ctl_rx_enable", edges);
        check_value(32'(edges), 32'd2, "edges from rx disable to re-arm");
        check_value(32'(ctl_tx_send_lfi), 32'd1, "ctl_tx_send_lfi after re-arm");
        repeat (400) begin
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0) begin
                stat_rx_aligned = !stat_rx_aligned;
            end
            tick();
        end
        report_test("alignment loss and random toggling", test_errs);

        test_errs = errors;
        stat_rx_aligned = 1'b1;
        repeat (400) begin
            drive_traffic();
            tick();
        end
        zero_stats();
        repeat (3) tick();  // let the capture and counter stages drain
        read_counters(0, 7);
        report_test("packet and byte counters", test_errs);

        test_errs = errors;
        repeat (400) begin
            drive_errors();
            tick();
        end
        zero_stats();
        repeat (3) tick();
        read_counters(0, 14);
        report_test("error counters", test_errs);

        test_errs = errors;
        stat_sel = cmac_pkg::stat_id_e'(4'd15);
        tick();
        check_value(rd_data, 32'd0, "rd_data for select code 15");
        usr_rx_reset_w = 1'b1;
        repeat (4) tick();
        usr_rx_reset_w = 1'b0;
        read_counters(0, 14);  // model sums are zero after reset
        report_test("readout and reset", test_errs);

        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
cmac_pkg.sv
stat_bus_if.sv
link_bringup.sv
stat_capture.sv
stat_counter.sv
stat_readout.sv
cmac_link_ctrl.sv
cmac_link_ctrl_properties.sv
tb_cmac_link_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cmac link control testbench with verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_cmac_link_ctrl \
    -o sim_cmac_link_ctrl

# the simulation may stop on an assertion, so its status is judged from the log
./obj_dir/sim_cmac_link_ctrl 2>&1 | tee sim.log || true

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
